//--- run.sh
#!/bin/sh
# Build the decode front-end testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tb_decode -f tb.f -o Vtb_decode
./obj_dir/Vtb_decode > sim.log 2>&1
cat sim.log

if grep -q "Test failed" sim.log; then
	exit 1
fi
exit 0

//--- tb.f
verilog/QuplsPkg.sv
verilog/Qupls_fetch.sv
verilog/Qupls_instr_queue.sv
verilog/Qupls_decode_vec.sv
verilog/Qupls_decoder.sv
verilog/Qupls_decode_top.sv
test/decode_sva.sv
test/decode_chk.sv
test/tb_decode.sv

//--- test/decode_chk.sv
/*
 * Checker for the decode front end.
 * Watches the fetch strobe and the decoded outputs, predicts the pc of
 * every accepted word and compares each decodedValid beat in order.
 * Error counts and the number of outstanding words go back to the top.
 */
`timescale 1ns/100ps
`default_nettype none

module decode_chk
#(
	parameter logic [31:0] ResetPc = 32'hFFFC0000
)
(
	input  logic        clk,
	input  logic        reset,
	input  logic        flush,
	input  logic [31:0] flushPc,
	input  logic        fetchStrobe,
	input  logic [31:0] fetchWord,
	input  logic        expVec,
	input  logic        fetchReady,
	input  logic        decodeStall,
	input  logic        decodedValid,
	input  logic [31:0] decodedPc,
	input  logic [31:0] decodedInstr,
	input  logic        decodedIsVec,
	input  logic        endOfTest,
	output int          pending,
	output int          mismatchCount,
	output int          missingCount,
	output int          extraCount,
	output int          coverCount
);

	// Words accepted by fetch and not yet seen at the decoder output
	logic [31:0] expPc [$];
	logic [31:0] expWord [$];
	logic        expFlag [$];
	int          expCycle [$];
	logic        expTimed [$];
	logic [31:0] nextPc;
	int          cycle = 0;
	int          lastStall = 0;
	int          nMismatch = 0;
	int          nMissing = 0;
	int          nExtra = 0;
	int          nCover = 0;
	logic        sawFull = 1'b0;
	logic        reported = 1'b0;

	always @(posedge clk)
	begin
		logic bad;
		int   latency;
		cycle++;
		if (reset)
		begin
			expPc.delete();
			expWord.delete();
			expFlag.delete();
			expCycle.delete();
			expTimed.delete();
			nextPc = ResetPc;
		end
		else
		begin
			// ==========================================================
			// Compare the beat that was visible before this edge
			// ==========================================================
			if (decodedValid && expPc.size() == 0)
			begin
				nExtra++;
				$display("Extra decoded output at %0t for pc %h, nothing was outstanding",
					$time, decodedPc);
			end
			else if (decodedValid)
			begin
				bad = (decodedPc !== expPc[0]) || (decodedInstr !== expWord[0]) ||
					(decodedIsVec !== expFlag[0]);
				if (bad)
					$display("error at %0t: got pc %h instr %h vec %b, expected pc %h instr %h vec %b",
						$time, decodedPc, decodedInstr, decodedIsVec,
						expPc[0], expWord[0], expFlag[0]);
				// An idle pipe with no stall since the strobe has fixed latency
				latency = cycle - expCycle[0] - 1;
				if (expTimed[0] && lastStall < expCycle[0] && latency != 2)
				begin
					bad = 1'b1;
					$display("error at %0t: pc %h valid %0d edges after its strobe, expected 2",
						$time, decodedPc, latency);
				end
				if (bad)
					nMismatch++;
				void'(expPc.pop_front());
				void'(expWord.pop_front());
				void'(expFlag.pop_front());
				void'(expCycle.pop_front());
				void'(expTimed.pop_front());
			end

			// A flush throws away everything still in flight
			if (flush)
			begin
				expPc.delete();
				expWord.delete();
				expFlag.delete();
				expCycle.delete();
				expTimed.delete();
				nextPc = flushPc;
			end
			else if (fetchStrobe && fetchReady)
			begin
				expTimed.push_back(expPc.size() == 0);
				expPc.push_back(nextPc);
				expWord.push_back(fetchWord);
				expFlag.push_back(expVec);
				expCycle.push_back(cycle);
				nextPc = nextPc + 32'd4;
			end

			if (decodeStall)
				lastStall = cycle;
			if (!fetchReady)
				sawFull = 1'b1;
		end

		if (endOfTest && !reported)
		begin
			reported = 1'b1;
			nMissing = expPc.size();
			if (nMissing != 0)
				$display("%0d accepted words never came out of the decoder", nMissing);
			if (!sawFull)
			begin
				nCover++;
				$display("The queue never filled, fetchReady stayed high for the whole run");
			end
		end

		pending <= expPc.size();
		mismatchCount <= nMismatch;
		missingCount <= nMissing;
		extraCount <= nExtra;
		coverCount <= nCover;
	end

endmodule

`default_nettype wire

//--- test/decode_sva.sv
/*
 * Assertions on the instruction queue strobes.
 * Bound into every Qupls_instr_queue instance from the testbench top.
 */
`timescale 1ns/100ps
`default_nettype none

module decode_sva
(
	input logic clk,
	input logic reset,
	input logic flush,
	input logic wrStrobe,
	input logic rdStrobe,
	input logic full,
	input logic empty
);

	// A full queue with no pop has to stay full, so a write can never
	// push the count past the last slot
	writeWhileFull: assert property (@(posedge clk) disable iff (reset)
		full && !rdStrobe && !flush |=> full)
		else $error("Queue took a write while every slot was taken");

	// An empty queue with nothing written stays empty, so a pop can never
	// take the count below zero
	readWhileEmpty: assert property (@(posedge clk) disable iff (reset)
		empty && !wrStrobe |=> empty)
		else $error("Queue took a read while it was empty");

	// One reset edge is enough to clear the occupancy count
	emptyAfterReset: assert property (@(posedge clk) reset |=> empty)
		else $error("Queue not empty after reset");

endmodule

`default_nettype wire

//--- test/tb_decode.sv
/*
 * Testbench for the decode front end.
 * Builds a table of instruction words with their expected vector flag,
 * stall lengths and flushes, applies it to the DUT and leaves the
 * comparing to decode_chk. Assertions on the queue are bound here.
 */
`timescale 1ns/100ps
`default_nettype none

module tb_decode
	import QuplsPkg::*;
();

	localparam int          QueueDepth = 8;
	localparam logic [31:0] ResetPc    = 32'hFFFC0000;

	// One table row, a word with its expected flag and what to do around it
	typedef struct {
		logic [31:0] word;
		logic        vec;
		int          stall;
		logic        doFlush;
		logic [31:0] pc;
	} stimRow_t;

	logic        clk;
	logic        reset;
	logic        fetchStrobe;
	logic [31:0] fetchWord;
	logic        flush;
	logic [31:0] flushPc;
	logic        decodeStall;
	logic        expVec;
	logic        endOfTest;
	logic        fetchReady;
	logic        decodedValid;
	logic [31:0] decodedPc;
	logic [31:0] decodedInstr;
	logic        decodedIsVec;
	int          pending;
	int          mismatchCount;
	int          missingCount;
	int          extraCount;
	int          coverCount;
	stimRow_t    rows [$];
	integer      seed = 90597;
	int          stallLeft = 0;
	int          cycles = 0;
	int          limit = 0;
	int          total;

	Qupls_decode_top #(.QueueDepth(QueueDepth), .ResetPc(ResetPc)) Qupls_decode_top_inst
	(
		.clk          (clk),
		.reset        (reset),
		.fetchStrobe  (fetchStrobe),
		.fetchWord    (fetchWord),
		.flush        (flush),
		.flushPc      (flushPc),
		.decodeStall  (decodeStall),
		.fetchReady   (fetchReady),
		.decodedValid (decodedValid),
		.decodedPc    (decodedPc),
		.decodedInstr (decodedInstr),
		.decodedIsVec (decodedIsVec)
	);

	decode_chk #(.ResetPc(ResetPc)) decodeChkInst
	(
		.clk           (clk),
		.reset         (reset),
		.flush         (flush),
		.flushPc       (flushPc),
		.fetchStrobe   (fetchStrobe),
		.fetchWord     (fetchWord),
		.expVec        (expVec),
		.fetchReady    (fetchReady),
		.decodeStall   (decodeStall),
		.decodedValid  (decodedValid),
		.decodedPc     (decodedPc),
		.decodedInstr  (decodedInstr),
		.decodedIsVec  (decodedIsVec),
		.endOfTest     (endOfTest),
		.pending       (pending),
		.mismatchCount (mismatchCount),
		.missingCount  (missingCount),
		.extraCount    (extraCount),
		.coverCount    (coverCount)
	);

	bind Qupls_instr_queue decode_sva queueChecks
	(
		.clk      (clk),
		.reset    (reset),
		.flush    (flush),
		.wrStrobe (wrStrobe),
		.rdStrobe (rdStrobe),
		.full     (full),
		.empty    (empty)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Register fields and the mask are random, only opcode and func matter
	function automatic logic [31:0] encode(input logic [6:0] op, input logic [6:0] fn);
		return {3'($random(seed)), fn, 5'($random(seed)), 5'($random(seed)),
			5'($random(seed)), op};
	endfunction

	task automatic addRow(input logic [31:0] word, input logic vec, input int stall,
		input logic doFlush, input logic [31:0] pc);
		stimRow_t row;
		row.word = word;
		row.vec = vec;
		row.stall = stall;
		row.doFlush = doFlush;
		row.pc = pc;
		rows.push_back(row);
	endtask

	// ====================================================================
	// Stimulus table
	// ====================================================================
	task automatic buildTable();
		logic [6:0] vecFuncs [27] = '{FN_ADD, FN_CMP, FN_MUL, FN_MULW, FN_DIV, FN_SUB,
			FN_MULU, FN_MULUW, FN_DIVU, FN_AND, FN_OR, FN_EOR, FN_NAND, FN_NOR, FN_ENOR,
			FN_SEQ, FN_SNE, FN_SLT, FN_SLE, FN_SLTU, FN_SLEU,
			FN_ZSEQ, FN_ZSNE, FN_ZSLT, FN_ZSLE, FN_ZSLTU, FN_ZSLEU};
		logic [6:0] vecOps [12] = '{OP_VADDI, OP_VCMPI, OP_VMULI, OP_VDIVI, OP_VANDI,
			OP_VORI, OP_VEORI, OP_VADDSI, OP_VORSI, OP_VANDSI, OP_VEORSI, OP_VSHIFT};
		// Scalar forms, including the move and an unlisted function
		addRow(encode(OP_CHK, FN_ADD), 1'b0, 0, 1'b0, '0);
		addRow(encode(OP_ADDI, FN_SUB), 1'b0, 0, 1'b0, '0);
		addRow(encode(OP_R3, FN_ADD), 1'b0, 0, 1'b0, '0);
		addRow(encode(OP_R3V, FN_MOV), 1'b0, 0, 1'b0, '0);
		addRow(encode(OP_R3VS, FN_MOV), 1'b0, 0, 1'b0, '0);
		addRow(encode(OP_R3V, 7'h7F), 1'b0, 0, 1'b0, '0);
		foreach (vecOps[i])
			addRow(encode(vecOps[i], FN_AND), 1'b1, 0, 1'b0, '0);
		// Four words sit behind a stall and are then flushed away
		addRow(encode(OP_ADDI, FN_ADD), 1'b0, 24, 1'b0, '0);
		addRow(encode(OP_VORI, FN_ADD), 1'b1, 0, 1'b0, '0);
		addRow(encode(OP_R3, FN_OR), 1'b0, 0, 1'b0, '0);
		addRow(encode(OP_VSHIFT, FN_OR), 1'b1, 0, 1'b0, '0);
		addRow(encode(OP_R3VS, FN_SUB), 1'b1, 0, 1'b1, 32'h0000_2000);
		// Long stall at the start of this group fills the queue
		foreach (vecFuncs[i])
			addRow(encode((i % 2) ? OP_R3VS : OP_R3V, vecFuncs[i]), 1'b1,
				(i == 0) ? 40 : 0, 1'b0, '0);
	endtask

	// One clock edge, with the stall level kept up while the count runs
	task automatic tick();
		@(posedge clk);
		if (stallLeft > 0)
		begin
			decodeStall <= 1'b1;
			stallLeft--;
		end
		else
			decodeStall <= 1'b0;
	endtask

	// The strobe stays up until an edge where fetchReady was high
	task automatic sendWord(input logic [31:0] word, input logic vec);
		fetchWord <= word;
		expVec <= vec;
		fetchStrobe <= 1'b1;
		tick();
		while (!fetchReady)
			tick();
		fetchStrobe <= 1'b0;
	endtask

	task automatic applyFlush(input logic [31:0] pc);
		flush <= 1'b1;
		flushPc <= pc;
		tick();
		flush <= 1'b0;
	endtask

	// Run limit scales with the table
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit)
		begin
			$display("Timeout after %0d cycles, the DUT stopped producing output", limit);
			$display("Errors: %0d mismatched, %0d missing, %0d extra, %0d coverage",
				mismatchCount, missingCount, extraCount, coverCount);
			$display("Test failed");
			$finish;
		end
	end

	initial
	begin
		reset = 1'b1;
		fetchStrobe = 1'b0;
		fetchWord = '0;
		flush = 1'b0;
		flushPc = '0;
		decodeStall = 1'b0;
		expVec = 1'b0;
		endOfTest = 1'b0;
		buildTable();
		limit = rows.size() * 40;
		repeat (16) @(posedge clk);
		reset <= 1'b0;

		foreach (rows[i])
		begin
			if (rows[i].stall != 0)
				stallLeft = rows[i].stall;
			if (rows[i].doFlush)
				applyFlush(rows[i].pc);
			repeat ($unsigned($random(seed)) % 4)
				tick();
			sendWord(rows[i].word, rows[i].vec);
		end

		// Let the pipe drain, then watch a few idle edges for stray output
		stallLeft = 0;
		while (pending != 0)
			tick();
		repeat (6)
			tick();
		endOfTest <= 1'b1;
		repeat (2)
			tick();

		total = mismatchCount + missingCount + extraCount + coverCount;
		$display("Errors: %0d mismatched, %0d missing, %0d extra, %0d coverage",
			mismatchCount, missingCount, extraCount, coverCount);
		if (total == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/QuplsPkg.sv
/*
 * Shared types for the decode front end of the core.
 * Holds the major opcodes, the register-form function codes, the
 * instruction layout and the item that travels from fetch to decode.
 * Modules pull these in with a wildcard import in their header.
 */
`default_nettype none

package QuplsPkg;

	// ====================================================================
	// Major opcodes
	// ====================================================================
	typedef enum logic [6:0] {
		OP_CHK    = 7'h03,
		OP_R3     = 7'h02,
		OP_ADDI   = 7'h04,
		// Vector register forms, plain and with a scalar operand
		OP_R3V    = 7'h50,
		OP_R3VS   = 7'h51,
		// Vector with immediate
		OP_VADDI  = 7'h54,
		OP_VCMPI  = 7'h55,
		OP_VMULI  = 7'h56,
		OP_VDIVI  = 7'h57,
		OP_VANDI  = 7'h58,
		OP_VORI   = 7'h59,
		OP_VEORI  = 7'h5A,
		// Vector with scalar immediate
		OP_VADDSI = 7'h5B,
		OP_VORSI  = 7'h5C,
		OP_VANDSI = 7'h5D,
		OP_VEORSI = 7'h5E,
		OP_VSHIFT = 7'h5F
	} opcode_t;

	// ====================================================================
	// Function codes for the register forms
	// ====================================================================
	typedef enum logic [6:0] {
		FN_ADD   = 7'h04, FN_CMP   = 7'h05, FN_MUL   = 7'h06, FN_MULW  = 7'h07,
		FN_DIV   = 7'h08, FN_SUB   = 7'h09, FN_MULU  = 7'h0A, FN_MULUW = 7'h0B,
		FN_DIVU  = 7'h0C, FN_AND   = 7'h10, FN_OR    = 7'h11, FN_EOR   = 7'h12,
		FN_NAND  = 7'h14, FN_NOR   = 7'h15, FN_ENOR  = 7'h16, FN_SEQ   = 7'h20,
		FN_SNE   = 7'h21, FN_SLT   = 7'h22, FN_SLE   = 7'h23, FN_SLTU  = 7'h24,
		FN_SLEU  = 7'h25, FN_ZSEQ  = 7'h28, FN_ZSNE  = 7'h29, FN_ZSLT  = 7'h2A,
		FN_ZSLE  = 7'h2B, FN_ZSLTU = 7'h2C, FN_ZSLEU = 7'h2D,
		// Register move exists only in scalar form
		FN_MOV   = 7'h30
	} func_t;

	// Register-form layout, declared high field first so the opcode
	// ends up in the low seven bits
	typedef struct packed {
		logic [2:0] vmask;
		func_t      func;
		logic [4:0] Rb;
		logic [4:0] Ra;
		logic [4:0] Rt;
		opcode_t    opcode;
	} r2Instr_t;

	// The raw view lets a fetched word be loaded without a cast
	typedef union packed {
		logic [31:0] raw;
		r2Instr_t    r2;
	} instruction_t;

	// One queue entry, the instruction together with its address
	typedef struct packed {
		logic [31:0]  pc;
		instruction_t instr;
	} fetchItem_t;

endpackage

`default_nettype wire

//--- verilog/Qupls_decode_top.sv
/*
 * Top level of the decode front end.
 * Connects fetch, the instruction queue and the decoder, and sets the
 * queue depth and the reset address for the blocks below.
 */
`timescale 1ns/100ps
`default_nettype none

module Qupls_decode_top
	import QuplsPkg::*;
#(
	parameter int          QueueDepth = 8,
	parameter logic [31:0] ResetPc    = 32'hFFFC0000
)
(
	input  logic        clk,
	input  logic        reset,
	input  logic        fetchStrobe,
	input  logic [31:0] fetchWord,
	input  logic        flush,
	input  logic [31:0] flushPc,
	input  logic        decodeStall,
	output logic        fetchReady,
	output logic        decodedValid,
	output logic [31:0] decodedPc,
	output logic [31:0] decodedInstr,
	output logic        decodedIsVec
);

	logic       wrStrobe;
	logic       rdStrobe;
	logic       full;
	logic       empty;
	fetchItem_t wrItem;
	fetchItem_t rdItem;

	// Fetch may present a word whenever the queue has a free slot
	assign fetchReady = ~full;

	Qupls_fetch #(.ResetPc(ResetPc)) fetchInst
	(
		.clk         (clk),
		.reset       (reset),
		.fetchStrobe (fetchStrobe),
		.fetchWord   (fetchWord),
		.flush       (flush),
		.flushPc     (flushPc),
		.full        (full),
		.wrStrobe    (wrStrobe),
		.wrItem      (wrItem)
	);

	Qupls_instr_queue #(.QueueDepth(QueueDepth), .itemType(fetchItem_t)) queueInst
	(
		.clk      (clk),
		.reset    (reset),
		.flush    (flush),
		.wrStrobe (wrStrobe),
		.wrItem   (wrItem),
		.rdStrobe (rdStrobe),
		.rdItem   (rdItem),
		.full     (full),
		.empty    (empty)
	);

	Qupls_decoder decoderInst
	(
		.clk          (clk),
		.reset        (reset),
		.flush        (flush),
		.decodeStall  (decodeStall),
		.rdItem       (rdItem),
		.empty        (empty),
		.rdStrobe     (rdStrobe),
		.decodedValid (decodedValid),
		.decodedPc    (decodedPc),
		.decodedInstr (decodedInstr),
		.decodedIsVec (decodedIsVec)
	);

endmodule

`default_nettype wire

//--- verilog/Qupls_decode_vec.sv
/*
 * Vector classifier for one instruction.
 * Purely combinational, it flags the register, immediate, scalar
 * immediate and shift forms that operate on vector registers.
 */
`timescale 1ns/100ps
`default_nettype none

module Qupls_decode_vec
	import QuplsPkg::*;
(
	input  instruction_t instr,
	output logic         vec
);

	always_comb
	begin
		case (instr.r2.opcode)
		// Check instructions share the encoding space but are scalar
		OP_CHK:
			vec = 1'b0;
		// Register forms are vector only for the arithmetic, logic and
		// set functions below
		OP_R3V, OP_R3VS:
			case (instr.r2.func)
			FN_ADD, FN_CMP, FN_MUL, FN_MULW, FN_DIV, FN_SUB:
				vec = 1'b1;
			FN_MULU, FN_MULUW, FN_DIVU:
				vec = 1'b1;
			FN_AND, FN_OR, FN_EOR, FN_NAND, FN_NOR, FN_ENOR:
				vec = 1'b1;
			FN_SEQ, FN_SNE, FN_SLT, FN_SLE, FN_SLTU, FN_SLEU:
				vec = 1'b1;
			FN_ZSEQ, FN_ZSNE, FN_ZSLT, FN_ZSLE, FN_ZSLTU, FN_ZSLEU:
				vec = 1'b1;
			// Move and any unknown function stay scalar
			default:
				vec = 1'b0;
			endcase
		// Every immediate form in the vector group
		OP_VADDI, OP_VCMPI, OP_VMULI, OP_VDIVI:
			vec = 1'b1;
		OP_VANDI, OP_VORI, OP_VEORI:
			vec = 1'b1;
		// Scalar immediate broadcast to all lanes
		OP_VADDSI, OP_VORSI, OP_VANDSI, OP_VEORSI:
			vec = 1'b1;
		OP_VSHIFT:
			vec = 1'b1;
		default:
			vec = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/Qupls_decoder.sv
/*
 * Decode stage consumer.
 * Pops the head of the instruction queue once per unstalled cycle,
 * classifies it and registers the pc, the word and the vector flag.
 * decodedValid marks each popped item for one cycle.
 */
`timescale 1ns/100ps
`default_nettype none

module Qupls_decoder
	import QuplsPkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  logic         flush,
	input  logic         decodeStall,
	input  fetchItem_t   rdItem,
	input  logic         empty,
	output logic         rdStrobe,
	output logic         decodedValid,
	output logic [31:0]  decodedPc,
	output instruction_t decodedInstr,
	output logic         decodedIsVec
);

	logic isVec;

	// Pop whenever something is waiting and downstream can take it
	assign rdStrobe = ~empty & ~decodeStall;

	// Classifier looks at the head entry before it is popped
	Qupls_decode_vec decodeVecInst
	(
		.instr (rdItem.instr),
		.vec   (isVec)
	);

	// ====================================================================
	// Output registers
	// ====================================================================

	// Valid flag is control state and follows reset and flush
	always_ff @(posedge clk)
	begin
		if (reset || flush)
			decodedValid <= 1'b0;
		else
			decodedValid <= rdStrobe;
	end

	// Result fields only change on a pop
	always_ff @(posedge clk)
	begin
		if (rdStrobe)
		begin
			decodedPc <= rdItem.pc;
			decodedInstr <= rdItem.instr;
			decodedIsVec <= isVec;
		end
	end

endmodule

`default_nettype wire

//--- verilog/Qupls_fetch.sv
/*
 * Fetch stage of the decode front end.
 * Takes one instruction word per strobe, tags it with its program
 * counter and offers it to the instruction queue from a one-entry stage.
 */
`timescale 1ns/100ps
`default_nettype none

module Qupls_fetch
	import QuplsPkg::*;
#(
	parameter logic [31:0] ResetPc = 32'hFFFC0000
)
(
	input  logic        clk,
	input  logic        reset,
	input  logic        fetchStrobe,
	input  logic [31:0] fetchWord,
	input  logic        flush,
	input  logic [31:0] flushPc,
	input  logic        full,
	output logic        wrStrobe,
	output fetchItem_t  wrItem
);

	// Address that the next accepted word will carry
	logic [31:0] pc;
	logic        stageValid;
	logic        accept;

	// A word is taken only while the queue has room
	assign accept = fetchStrobe & ~full & ~flush;

	// The staged item waits here whenever the queue is full
	assign wrStrobe = stageValid & ~full;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc <= ResetPc;
			stageValid <= 1'b0;
		end
		else if (flush)
		begin
			// Redirect drops the staged word and restarts the count
			pc <= flushPc;
			stageValid <= 1'b0;
		end
		else if (accept)
		begin
			pc <= pc + 32'd4;
			stageValid <= 1'b1;
		end
		else if (wrStrobe)
			stageValid <= 1'b0;
	end

	// Payload register, loaded only when a word is accepted
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			wrItem.pc <= pc;
			wrItem.instr <= fetchWord;
		end
	end

endmodule

`default_nettype wire

//--- verilog/Qupls_instr_queue.sv
/*
 * Circular instruction queue between fetch and decode.
 * The payload type is a parameter so the same buffer can carry other
 * items in the core. Writes and reads are strobes, full and empty are
 * levels, and the head entry is shown without a register.
 */
`timescale 1ns/100ps
`default_nettype none

module Qupls_instr_queue
#(
	parameter int  QueueDepth = 8,
	parameter type itemType   = logic [63:0]
)
(
	input  logic    clk,
	input  logic    reset,
	input  logic    flush,
	input  logic    wrStrobe,
	input  itemType wrItem,
	input  logic    rdStrobe,
	output itemType rdItem,
	output logic    full,
	output logic    empty
);

	// ====================================================================
	// Storage and pointers
	// ====================================================================
	localparam int PtrW   = $clog2(QueueDepth);
	localparam int CountW = PtrW + 1;

	itemType           mem [QueueDepth];
	logic [PtrW-1:0]   wrPtr;
	logic [PtrW-1:0]   rdPtr;
	logic [CountW-1:0] count;
	logic              doWrite;
	logic              doRead;

	// Strobes against a full or empty queue are ignored
	assign doWrite = wrStrobe & ~full & ~flush;
	assign doRead = rdStrobe & ~empty & ~flush;

	assign full = (count == CountW'(QueueDepth));
	assign empty = (count == '0);

	// Head of the queue goes straight out to the decoder
	assign rdItem = mem[rdPtr];

	// Entries carry no reset and are only valid while counted
	always_ff @(posedge clk)
	begin
		if (doWrite)
			mem[wrPtr] <= wrItem;
	end

	// ====================================================================
	// Pointer and occupancy control
	// ====================================================================
	always_ff @(posedge clk)
	begin
		if (reset || flush)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			// Depth is a power of two so the pointers wrap on their own
			if (doWrite)
				wrPtr <= wrPtr + 1'b1;
			if (doRead)
				rdPtr <= rdPtr + 1'b1;
			// A read and a write in the same cycle leave the count alone
			case ({doWrite, doRead})
			2'b10:   count <= count + 1'b1;
			2'b01:   count <= count - 1'b1;
			default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire
